// ==== compile.f ====
+incdir+verilog
verilog/codec_init_pkg.sv
verilog/codec_init_rom.sv
verilog/i2c_bit_timer.sv
verilog/i2c_frame_shifter.sv
verilog/codec_init_fsm.sv
verilog/codec_apb_regs.sv
verilog/codec_init_top.sv
dv/tb_clk_gen.sv
dv/i2c_codec_model.sv
dv/tb_codec_init.sv

// ==== dv/i2c_codec_model.sv ====
`timescale 1ns/100ps

module i2c_codec_model (
    input  logic i_scl,
    input  logic i_sda_o,
    input  logic i_sda_oe,
    input  logic i_nack_en,
    input  int   i_nack_frame,    // Frame number, counted over the whole simulation
    output logic o_sda
);

    logic [23:0] rx_q[$];         // {addr byte, reg word} per complete frame
    logic [26:0] shift_q    = '0;
    int          bit_cnt    = 0;
    int          start_cnt  = 0;
    int          stop_cnt   = 0;
    int          start_seen = 0;
    logic        pull       = 1'b0;

    // Pull-up plus wired-AND of master and codec
    assign o_sda = (i_sda_oe ? i_sda_o : 1'b1) & !pull;

    always @(negedge o_sda) begin
        if (i_scl === 1'b1) begin
            start_cnt = start_cnt + 1;
        end
    end

    // Only a STOP that closes an open frame counts
    always @(posedge o_sda) begin
        if (i_scl === 1'b1 && start_cnt > stop_cnt) begin
            stop_cnt = stop_cnt + 1;
        end
    end

    always @(posedge i_scl) begin
        if (start_cnt > stop_cnt) begin
            if (start_cnt != start_seen) begin   // First bit after a new START
                start_seen = start_cnt;
                bit_cnt    = 0;
            end
            shift_q = {shift_q[25:0], o_sda};
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 27) begin
                rx_q.push_back({shift_q[26:19], shift_q[17:10], shift_q[8:1]});
            end
        end
    end

    // ACK slots follow bits 8, 17 and 26, held from SCL fall to SCL fall
    always @(negedge i_scl) begin
        pull = ((bit_cnt == 8) || (bit_cnt == 17) || (bit_cnt == 26))
            && !(i_nack_en && (rx_q.size() == i_nack_frame));
    end

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Reset held over three rising edges, released on a falling edge
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

// ==== dv/tb_codec_init.sv ====
`timescale 1ns/100ps
`include "codec_init_defs.svh"

module tb_codec_init
    import codec_init_pkg::*;
();

    localparam int RUNS        = 12;
    localparam int DONE_POLLS  = 3000;
    localparam int RESET_LIMIT = 20;

    logic      clk;
    logic      rst_n;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;
    i2c_pins_t pins;
    logic      sda_bus;
    logic      nack_en;
    int        nack_frame;
    integer    seed;

    tb_clk_gen clk_gen_i (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    codec_init_top dut_i (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_apb   (apb_req),
        .o_apb   (apb_rsp),
        .i_sda   (sda_bus),
        .o_i2c   (pins)
    );

    i2c_codec_model codec_i (
        .i_scl        (pins.scl),
        .i_sda_o      (pins.sda_o),
        .i_sda_oe     (pins.sda_oe),
        .i_nack_en    (nack_en),
        .i_nack_frame (nack_frame),
        .o_sda        (sda_bus)
    );

    // Reference copy of the power-up table
    function automatic logic [15:0] table_word(input int idx);
        case (idx)
            0:       return 16'h1E00;
            1:       return 16'h0815;
            2:       return 16'h0A00;
            3:       return 16'h0C00;
            4:       return 16'h0E42;
            5:       return 16'h1019;
            default: return 16'h1201;
        endcase
    endfunction

    function automatic logic [31:0] status_word(input logic busy, input logic done,
                                                input logic ack_err, input logic [2:0] idx);
        logic [31:0] w;
        w      = '0;
        w[0]   = busy;
        w[1]   = done;
        w[2]   = ack_err;
        w[6:4] = idx;
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Verification failed");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    // Setup on one falling edge, access on the next, sampled mid-cycle
    task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic slverr);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #10;
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            if (cycles == RESET_LIMIT) begin
                $display("Verification failed");
                $fatal(1, "Reset was never released");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic wait_done(input string name);
        apb_data_t rd;
        logic      err;
        int        polls;
        polls = 0;
        rd    = '0;
        while (rd[1] !== 1'b1) begin
            if (polls == DONE_POLLS) begin
                $display("Verification failed");
                $fatal(1, "Timed out waiting for the done bit in %s", name);
            end
            apb_access(1'b0, `REG_STATUS, '0, rd, err);
            polls++;
        end
    endtask

    task automatic check_idle_pins(input string name);
        check_value({name, " SCL"}, 32'd1, 32'(pins.scl));
        check_value({name, " SDA output"}, 32'd1, 32'(pins.sda_o));
        check_value({name, " SDA output enable"}, 32'd0, 32'(pins.sda_oe));
    endtask

    task automatic check_unmapped(input string name);
        apb_data_t status_before;
        apb_data_t words_before;
        apb_data_t rd;
        logic      err;
        apb_access(1'b0, `REG_STATUS, '0, status_before, err);
        apb_access(1'b0, `REG_WORDS, '0, words_before, err);
        apb_access(1'b1, 8'h01, 32'h1, rd, err);    // Looks like a start, must not start
        check_value({name, " write 0x01 pslverr"}, 32'd1, 32'(err));
        apb_access(1'b1, 8'h0C, 32'h3, rd, err);
        check_value({name, " write 0x0C pslverr"}, 32'd1, 32'(err));
        apb_access(1'b0, 8'h10, '0, rd, err);
        check_value({name, " read 0x10 pslverr"}, 32'd1, 32'(err));
        apb_access(1'b0, `REG_STATUS, '0, rd, err);
        check_value({name, " STATUS kept"}, status_before, rd);
        apb_access(1'b0, `REG_WORDS, '0, rd, err);
        check_value({name, " WORDS kept"}, words_before, rd);
    endtask

    task automatic run_sequence(input int run_no);
        string       tag;
        logic [31:0] raw;
        int          count;
        logic        use_nack;
        logic        poke;
        int          k;
        int          base;
        int          exp_frames;
        apb_data_t   rd;
        logic        err;
        tag      = $sformatf("run %0d", run_no);
        raw      = {$random(seed)} % 8;
        count    = (raw == 0) ? 1 : raw;    // Zero is stored as one
        use_nack = ({$random(seed)} % 2) == 1;
        k        = {$random(seed)} % count;
        poke     = ({$random(seed)} % 2) == 1;
        apb_access(1'b1, `REG_WORDS, raw, rd, err);
        check_value({tag, " WORDS write pslverr"}, 32'd0, 32'(err));
        apb_access(1'b0, `REG_WORDS, '0, rd, err);
        check_value({tag, " WORDS readback"}, 32'(count), rd);
        base       = codec_i.rx_q.size();
        nack_en    = use_nack;
        nack_frame = base + k;
        apb_access(1'b1, `REG_CTRL, 32'h1, rd, err);
        check_value({tag, " CTRL write pslverr"}, 32'd0, 32'(err));
        if (poke) begin
            apb_access(1'b0, `REG_STATUS, '0, rd, err);
            check_value({tag, " STATUS while busy"}, status_word(1'b1, 1'b0, 1'b0, 3'd0), rd);
            apb_access(1'b1, `REG_CTRL, 32'h1, rd, err);   // Dropped while busy
        end
        wait_done(tag);
        exp_frames = use_nack ? k + 1 : count;
        check_value({tag, " frame count"}, 32'(exp_frames), 32'(codec_i.rx_q.size() - base));
        for (int i = 0; i < exp_frames; i++) begin
            check_value($sformatf("%s frame %0d", tag, i),
                        32'({8'h34, table_word(i)}),
                        32'(codec_i.rx_q[base + i]));
        end
        apb_access(1'b0, `REG_STATUS, '0, rd, err);
        check_value({tag, " final STATUS"},
                    status_word(1'b0, 1'b1, use_nack, use_nack ? 3'(k) : 3'd0), rd);
        check_idle_pins({tag, " pins"});
        nack_en = 1'b0;
    endtask

    initial begin
        apb_data_t rd;
        logic      err;
        seed       = 14517;
        apb_req    = '0;
        nack_en    = 1'b0;
        nack_frame = 0;
        wait_reset_release();
        check_idle_pins("reset pins");
        apb_access(1'b0, `REG_STATUS, '0, rd, err);
        check_value("reset STATUS", 32'h0, rd);
        apb_access(1'b0, `REG_WORDS, '0, rd, err);
        check_value("reset WORDS", 32'd7, rd);
        check_unmapped("after reset");
        apb_access(1'b1, `REG_WORDS, 32'd0, rd, err);
        apb_access(1'b0, `REG_WORDS, '0, rd, err);
        check_value("WORDS zero write", 32'd1, rd);
        for (int r = 0; r < RUNS; r++) begin
            run_sequence(r);
        end
        check_unmapped("after runs");
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the codec init testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module tb_codec_init \
    -Mdir obj_dir -o tb_codec_init \
    && ./obj_dir/tb_codec_init \
    || { echo "simulation did not complete cleanly"; exit 1; }

// ==== verilog/codec_apb_regs.sv ====
`timescale 1ns/100ps
`include "codec_init_defs.svh"

module codec_apb_regs
    import codec_init_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  apb_req_t     i_apb,
    output apb_rsp_t     o_apb,
    input  init_status_t i_status,
    output logic         o_go,
    output word_idx_t    o_words
);

    logic      access;
    logic      wr_en;
    logic      rd_en;
    logic      hit_ctrl;
    logic      hit_status;
    logic      hit_words;
    logic      mapped;
    word_idx_t words_q;
    word_idx_t words_d;
    apb_data_t rd_data;

    assign access = i_apb.psel && i_apb.penable;    // Always ready, one access cycle
    assign wr_en  = access && i_apb.pwrite;
    assign rd_en  = access && !i_apb.pwrite;

    assign hit_ctrl   = (i_apb.paddr == `REG_CTRL);
    assign hit_status = (i_apb.paddr == `REG_STATUS);
    assign hit_words  = (i_apb.paddr == `REG_WORDS);
    assign mapped     = hit_ctrl || hit_status || hit_words;

    // Count kept in 1..7
    always_comb begin
        if (i_apb.pwdata == '0) begin
            words_d = word_idx_t'(1);
        end else if (i_apb.pwdata > apb_data_t'(`CODEC_INIT_WORDS)) begin
            words_d = word_idx_t'(`CODEC_INIT_WORDS);
        end else begin
            words_d = i_apb.pwdata[2:0];
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            words_q <= word_idx_t'(`CODEC_INIT_WORDS);
        end else if (wr_en && hit_words) begin
            words_q <= words_d;
        end
    end

    // Start request is dropped while a run is in progress
    assign o_go    = wr_en && hit_ctrl && i_apb.pwdata[0] && !i_status.busy;
    assign o_words = words_q;

    always_comb begin
        rd_data = '0;
        if (hit_status) begin
            rd_data = {25'd0, i_status.err_idx, 1'b0, i_status.ack_err,
                       i_status.done, i_status.busy};
        end else if (hit_words) begin
            rd_data = {29'd0, words_q};
        end
    end

    assign o_apb.prdata  = rd_en ? rd_data : '0;
    assign o_apb.pslverr = access && !mapped;

    // Go only in an access phase that follows a setup phase
    a_go_access: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_go |-> i_apb.penable && $past(i_apb.psel && !i_apb.penable));

    a_go_accepted: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_go |=> i_status.busy);

endmodule

// ==== verilog/codec_init_defs.svh ====
`ifndef CODEC_INIT_DEFS_SVH
`define CODEC_INIT_DEFS_SVH

// 7-bit codec bus address, write byte becomes 0x34
`define CODEC_DEV_ADDR 7'h1A

// System clocks per quarter bit, 2 or more
`define I2C_QTR_DIV 4

// Number of words in the power-up table
`define CODEC_INIT_WORDS 7

// APB byte offsets
`define REG_CTRL   8'h00
`define REG_STATUS 8'h04
`define REG_WORDS  8'h08

`endif

// ==== verilog/codec_init_fsm.sv ====
`timescale 1ns/100ps
`include "codec_init_defs.svh"

module codec_init_fsm
    import codec_init_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_go,
    input  word_idx_t    i_words,
    input  logic         i_bit_end,
    input  logic         i_frame_done,
    input  logic         i_nack,
    output logic         o_run,
    output word_idx_t    o_idx,
    output logic         o_load,
    output logic         o_cond_start,
    output logic         o_cond_stop,
    output logic         o_shift_en,
    output init_status_t o_status
);

    seq_state_e   state_q;
    word_idx_t    idx_q;
    word_idx_t    words_q;      // Count latched at go
    logic         load_q;
    logic         gap_q;        // Second gap bit
    logic         nack_q;
    init_status_t status_q;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q  <= IDLE;
            idx_q    <= '0;
            words_q  <= '0;
            load_q   <= 1'b0;
            gap_q    <= 1'b0;
            nack_q   <= 1'b0;
            status_q <= '0;
        end else begin
            load_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (i_go) begin
                        state_q          <= START;
                        load_q           <= 1'b1;
                        idx_q            <= '0;
                        words_q          <= i_words;
                        status_q.busy    <= 1'b1;
                        status_q.done    <= 1'b0;
                        status_q.ack_err <= 1'b0;
                        status_q.err_idx <= '0;
                    end
                end
                START: if (i_bit_end) state_q <= BITS;
                BITS: begin
                    if (i_frame_done) begin
                        state_q <= STOP;
                        nack_q  <= i_nack;
                    end
                end
                STOP: begin
                    if (i_bit_end) begin
                        state_q <= GAP;
                        gap_q   <= 1'b0;
                    end
                end
                GAP: begin
                    if (i_bit_end) begin
                        gap_q <= 1'b1;
                        if (gap_q) state_q <= NEXT;
                    end
                end
                NEXT: begin
                    if (nack_q) begin
                        // Abort, remember which word failed
                        state_q          <= IDLE;
                        status_q.busy    <= 1'b0;
                        status_q.done    <= 1'b1;
                        status_q.ack_err <= 1'b1;
                        status_q.err_idx <= idx_q;
                    end else if (idx_q == words_q - 1'b1) begin
                        state_q       <= IDLE;
                        status_q.busy <= 1'b0;
                        status_q.done <= 1'b1;
                    end else begin
                        state_q <= START;
                        load_q  <= 1'b1;
                        idx_q   <= idx_q + 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Run drops in NEXT to realign the timer
    assign o_run        = (state_q inside {START, BITS, STOP, GAP});
    assign o_idx        = idx_q;
    assign o_load       = load_q;
    assign o_cond_start = (state_q == START);
    assign o_cond_stop  = (state_q == STOP);
    assign o_shift_en   = (state_q == BITS);
    assign o_status     = status_q;

    // Word is latched in START before the timer has finished any bit
    a_load_in_start: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_load |-> (state_q == START) && !i_bit_end);

    // ROM index stays inside the table while the bus is active
    a_idx_in_table: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_run |-> (o_idx < word_idx_t'(`CODEC_INIT_WORDS)));

endmodule

// ==== verilog/codec_init_pkg.sv ====
package codec_init_pkg;

    // Codec word is {reg_addr[6:0], data[8:0]}
    typedef logic [15:0] codec_word_t;
    typedef logic [2:0]  word_idx_t;    // Table index and word count
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic scl;
        logic sda_o;
        logic sda_oe;   // High drives sda_o, low releases the line
    } i2c_pins_t;

    typedef struct packed {
        logic      busy;
        logic      done;      // Sticky until the next go
        logic      ack_err;
        word_idx_t err_idx;
    } init_status_t;

    typedef enum logic [2:0] {IDLE, START, BITS, STOP, GAP, NEXT} seq_state_e;

endpackage

// ==== verilog/codec_init_rom.sv ====
`timescale 1ns/100ps
`include "codec_init_defs.svh"

module codec_init_rom
    import codec_init_pkg::*;
(
    input  word_idx_t   i_idx,
    output codec_word_t o_word
);

    // Anything past the table end reads the last entry
    always_comb begin
        case (i_idx)
            3'd0:    o_word = 16'h1E00;   // Reset
            3'd1:    o_word = 16'h0815;   // Analogue path, DAC selected
            3'd2:    o_word = 16'h0A00;   // Digital path
            3'd3:    o_word = 16'h0C00;   // Power down, all on
            3'd4:    o_word = 16'h0E42;   // Interface format, master, I2S
            3'd5:    o_word = 16'h1019;   // Sampling control
            3'd6:    o_word = 16'h1201;   // Active
            default: o_word = 16'h1201;
        endcase
    end

endmodule

// ==== verilog/codec_init_top.sv ====
`timescale 1ns/100ps

module codec_init_top (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  codec_init_pkg::apb_req_t    i_apb,
    output codec_init_pkg::apb_rsp_t    o_apb,
    input  logic                        i_sda,
    output codec_init_pkg::i2c_pins_t   o_i2c
);

    codec_init_pkg::init_status_t status;
    codec_init_pkg::word_idx_t    words;
    codec_init_pkg::word_idx_t    idx;
    codec_init_pkg::codec_word_t  word;
    logic                         go;
    logic                         run;
    logic                         load;
    logic                         cond_start;
    logic                         cond_stop;
    logic                         shift_en;
    logic                         qtick;
    logic [1:0]                   quarter;
    logic                         bit_end;
    logic                         frame_done;
    logic                         nack;

    codec_apb_regs regs_i (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_apb    (i_apb),
        .o_apb    (o_apb),
        .i_status (status),
        .o_go     (go),
        .o_words  (words)
    );

    codec_init_fsm fsm_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_go         (go),
        .i_words      (words),
        .i_bit_end    (bit_end),
        .i_frame_done (frame_done),
        .i_nack       (nack),
        .o_run        (run),
        .o_idx        (idx),
        .o_load       (load),
        .o_cond_start (cond_start),
        .o_cond_stop  (cond_stop),
        .o_shift_en   (shift_en),
        .o_status     (status)
    );

    i2c_bit_timer timer_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_run     (run),
        .o_qtick   (qtick),
        .o_quarter (quarter),
        .o_bit_end (bit_end)
    );

    codec_init_rom rom_i (
        .i_idx  (idx),
        .o_word (word)
    );

    i2c_frame_shifter shifter_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_load       (load),
        .i_word       (word),
        .i_qtick      (qtick),
        .i_quarter    (quarter),
        .i_cond_start (cond_start),
        .i_cond_stop  (cond_stop),
        .i_shift_en   (shift_en),
        .i_sda        (i_sda),
        .o_pins       (o_i2c),
        .o_frame_done (frame_done),
        .o_nack       (nack)
    );

endmodule

// ==== verilog/i2c_bit_timer.sv ====
`timescale 1ns/100ps
`include "codec_init_defs.svh"

module i2c_bit_timer (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_run,
    output logic       o_qtick,
    output logic [1:0] o_quarter,
    output logic       o_bit_end
);

    localparam int DIV   = `I2C_QTR_DIV;
    localparam int DIV_W = $clog2(DIV);

    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       quarter_q;

    // Both counters restart whenever run drops, so each frame starts at quarter 0
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            div_cnt   <= '0;
            quarter_q <= 2'd0;
        end else if (!i_run) begin
            div_cnt   <= '0;
            quarter_q <= 2'd0;
        end else if (o_qtick) begin
            div_cnt   <= '0;
            quarter_q <= quarter_q + 2'd1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Tick on the last clock of each quarter
    assign o_qtick   = (div_cnt == DIV_W'(DIV - 1));
    assign o_quarter = quarter_q;
    assign o_bit_end = o_qtick && (quarter_q == 2'd3);

    // Run only falls on a bit end, so the divider has already wrapped
    a_no_tick_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_run |-> !o_qtick);

endmodule

// ==== verilog/i2c_frame_shifter.sv ====
`timescale 1ns/100ps
`include "codec_init_defs.svh"

module i2c_frame_shifter
    import codec_init_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_load,
    input  codec_word_t i_word,
    input  logic        i_qtick,
    input  logic [1:0]  i_quarter,
    input  logic        i_cond_start,
    input  logic        i_cond_stop,
    input  logic        i_shift_en,
    input  logic        i_sda,
    output i2c_pins_t   o_pins,
    output logic        o_frame_done,
    output logic        o_nack
);

    localparam logic [7:0] ADDR_BYTE = {`CODEC_DEV_ADDR, 1'b0};
    localparam logic [4:0] LAST_SLOT = 5'd26;

    logic [26:0] frame_q;   // MSB is the slot on the bus
    logic [4:0]  slot_q;
    logic        nack_q;
    i2c_pins_t   pins_q;
    logic        ack_slot;
    logic        tick0;
    logic        tick1;
    logic        tick2;
    logic        tick3;

    assign ack_slot = (slot_q == 5'd8) || (slot_q == 5'd17) || (slot_q == LAST_SLOT);

    assign tick0 = i_qtick && (i_quarter == 2'd0);
    assign tick1 = i_qtick && (i_quarter == 2'd1);
    assign tick2 = i_qtick && (i_quarter == 2'd2);
    assign tick3 = i_qtick && (i_quarter == 2'd3);

    // ACK positions hold 1 so the line is released there
    always_ff @(posedge i_clk) begin
        if (i_load) begin
            frame_q <= {ADDR_BYTE, 1'b1, i_word[15:8], 1'b1, i_word[7:0], 1'b1};
        end else if (i_shift_en && tick3) begin
            frame_q <= {frame_q[25:0], 1'b1};
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pins_q <= '{scl: 1'b1, sda_o: 1'b1, sda_oe: 1'b0};
            slot_q <= 5'd0;
            nack_q <= 1'b0;
        end else begin
            if (i_load) begin
                slot_q <= 5'd0;
                nack_q <= 1'b0;
            end
            // START: SDA falls with SCL high
            if (i_cond_start) begin
                if (tick0) begin
                    pins_q.scl    <= 1'b1;
                    pins_q.sda_o  <= 1'b1;
                    pins_q.sda_oe <= 1'b1;
                end
                if (tick1) pins_q.sda_o <= 1'b0;
                if (tick3) pins_q.scl <= 1'b0;
            end
            if (i_shift_en) begin
                if (tick0) begin
                    pins_q.sda_oe <= !ack_slot;        // Codec owns SDA in ACK slots
                    if (!ack_slot) pins_q.sda_o <= frame_q[26];
                end
                if (tick1) pins_q.scl <= 1'b1;
                if (tick2 && ack_slot) nack_q <= nack_q | i_sda;   // High means NACK
                if (tick3) begin
                    pins_q.scl <= 1'b0;
                    slot_q     <= slot_q + 5'd1;
                end
            end
            // STOP: SDA rises with SCL high, then released
            if (i_cond_stop) begin
                if (tick0) begin
                    pins_q.sda_o  <= 1'b0;
                    pins_q.sda_oe <= 1'b1;
                end
                if (tick1) pins_q.scl <= 1'b1;
                if (tick2) pins_q.sda_o <= 1'b1;
                if (tick3) pins_q.sda_oe <= 1'b0;
            end
        end
    end

    assign o_pins       = pins_q;
    assign o_nack       = nack_q;
    assign o_frame_done = i_shift_en && tick3 && (slot_q == LAST_SLOT);

    // Data only moves while SCL is low, outside START and STOP
    a_sda_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (pins_q.sda_o != $past(pins_q.sda_o)) |->
            (!$past(pins_q.scl) || $past(i_cond_start || i_cond_stop)));

endmodule
